/* clock_consts.svh */
`ifndef CLOCK_CONSTS_SVH
`define CLOCK_CONSTS_SVH

// tick divisions, kept small so seconds pass quickly in simulation
`define CLK_PER_SECOND 16
`define CLK_PER_SCAN 2

// display width
`define NUM_DIGITS 6

// BCD field limits
`define MAX_SECONDS 8'h59
`define MAX_MINUTES 8'h59
`define MAX_HOURS 8'h23
`define PM_HOURS 8'h12

// active-low segment patterns, bit order g down to a
`define SEG_0 7'b1000000
`define SEG_1 7'b1111001
`define SEG_2 7'b0100100
`define SEG_3 7'b0110000
`define SEG_4 7'b0011001
`define SEG_5 7'b0010010
`define SEG_6 7'b0000010
`define SEG_7 7'b1111000
`define SEG_8 7'b0000000
`define SEG_9 7'b0010000
`define SEG_BLANK 7'b1111111

`endif

/* clockPkg.sv */
`include "clock_consts.svh"

package clockPkg;

    ////////////////////////////////////////////////////////////
    // time word
    ////////////////////////////////////////////////////////////

    // hours in the top byte, seconds in the bottom byte
    typedef struct packed {
        logic [7:0] hours;
        logic [7:0] minutes;
        logic [7:0] seconds;
    } hms_t;

    // digit 0 is the seconds ones, digit 5 the hours tens
    typedef union packed {
        logic [`NUM_DIGITS-1:0][3:0] digits;
        hms_t                        fields;
    } timeWord_t;

    ////////////////////////////////////////////////////////////
    // editable field
    ////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        FIELD_SEC  = 2'd0,
        FIELD_MIN  = 2'd1,
        FIELD_HOUR = 2'd2
    } field_t;

endpackage

/* tickGen.sv */
`timescale 1ns/10ps
`include "clock_consts.svh"

module tickGen (
    input  logic i_clk,
    input  logic i_rst,
    output logic o_secondTick,
    output logic o_scanTick
);

    localparam int SEC_W = ($clog2(`CLK_PER_SECOND) > 0) ? $clog2(`CLK_PER_SECOND) : 1;
    localparam int SCAN_W = ($clog2(`CLK_PER_SCAN) > 0) ? $clog2(`CLK_PER_SCAN) : 1;
    localparam logic [SEC_W-1:0] SEC_LAST = SEC_W'(`CLK_PER_SECOND - 1);
    localparam logic [SCAN_W-1:0] SCAN_LAST = SCAN_W'(`CLK_PER_SCAN - 1);

    logic [SEC_W-1:0]  secCount;
    logic [SCAN_W-1:0] scanCount;

    // seconds divider
    always_ff @(posedge i_clk) begin
        if (i_rst || secCount == SEC_LAST) begin
            secCount <= '0;
        end else begin
            secCount <= secCount + 1'b1;
        end
    end

    // digit scan divider
    always_ff @(posedge i_clk) begin
        if (i_rst || scanCount == SCAN_LAST) begin
            scanCount <= '0;
        end else begin
            scanCount <= scanCount + 1'b1;
        end
    end

    // one-cycle enables at terminal count
    assign o_secondTick = (secCount == SEC_LAST);
    assign o_scanTick = (scanCount == SCAN_LAST);

endmodule

/* timeKeeper.sv */
`timescale 1ns/10ps
`include "clock_consts.svh"

module timeKeeper #(
    parameter bit countMode = 1'b1
) (
    input  logic               i_clk,
    input  logic               i_rst,
    input  logic               i_advance,
    input  clockPkg::field_t   i_field,
    input  logic               i_inc,
    input  logic               i_dec,
    output clockPkg::timeWord_t o_time
);

    clockPkg::timeWord_t timeReg;
    clockPkg::timeWord_t editWord;
    clockPkg::timeWord_t nextWord;
    logic                editValid;

    ////////////////////////////////////////////////////////////
    // BCD helpers
    ////////////////////////////////////////////////////////////

    // two-digit BCD up count, wraps to zero after maxValue
    function automatic logic [7:0] bcdInc(input logic [7:0] value, input logic [7:0] maxValue);
        logic [7:0] result;
        if (value == maxValue) begin
            result = 8'h00;
        end else if (value[3:0] == 4'd9) begin
            result = {value[7:4] + 4'd1, 4'd0};
        end else begin
            result = {value[7:4], value[3:0] + 4'd1};
        end
        return result;
    endfunction

    // two-digit BCD down count, wraps to maxValue below zero
    function automatic logic [7:0] bcdDec(input logic [7:0] value, input logic [7:0] maxValue);
        logic [7:0] result;
        if (value == 8'h00) begin
            result = maxValue;
        end else if (value[3:0] == 4'd0) begin
            result = {value[7:4] - 4'd1, 4'd9};
        end else begin
            result = {value[7:4], value[3:0] - 4'd1};
        end
        return result;
    endfunction

    ////////////////////////////////////////////////////////////
    // field edit
    ////////////////////////////////////////////////////////////

    // both strobes together cancel out
    assign editValid = i_inc ^ i_dec;

    // only the chosen field moves, no carry into its neighbour
    always_comb begin : editLogic
        editWord = timeReg;
        case (i_field)
            clockPkg::FIELD_SEC: begin
                editWord.fields.seconds = i_inc ? bcdInc(timeReg.fields.seconds, `MAX_SECONDS)
                                                : bcdDec(timeReg.fields.seconds, `MAX_SECONDS);
            end
            clockPkg::FIELD_MIN: begin
                editWord.fields.minutes = i_inc ? bcdInc(timeReg.fields.minutes, `MAX_MINUTES)
                                                : bcdDec(timeReg.fields.minutes, `MAX_MINUTES);
            end
            clockPkg::FIELD_HOUR: begin
                editWord.fields.hours = i_inc ? bcdInc(timeReg.fields.hours, `MAX_HOURS)
                                              : bcdDec(timeReg.fields.hours, `MAX_HOURS);
            end
            default: begin
                editWord = timeReg;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // next state
    ////////////////////////////////////////////////////////////

    generate
        if (countMode) begin : genCount
            clockPkg::timeWord_t advanceWord;

            // seconds carry into minutes, minutes into hours
            always_comb begin
                advanceWord = timeReg;
                advanceWord.fields.seconds = bcdInc(timeReg.fields.seconds, `MAX_SECONDS);
                if (timeReg.fields.seconds == `MAX_SECONDS) begin
                    advanceWord.fields.minutes = bcdInc(timeReg.fields.minutes, `MAX_MINUTES);
                    if (timeReg.fields.minutes == `MAX_MINUTES) begin
                        advanceWord.fields.hours = bcdInc(timeReg.fields.hours, `MAX_HOURS);
                    end
                end
            end

            // an edit wins over the tick
            always_comb begin
                if (editValid) begin
                    nextWord = editWord;
                end else if (i_advance) begin
                    nextWord = advanceWord;
                end else begin
                    nextWord = timeReg;
                end
            end
        end else begin : genHold
            always_comb begin
                nextWord = editValid ? editWord : timeReg;
            end
        end
    endgenerate

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            timeReg <= '0;
        end else begin
            timeReg <= nextWord;
        end
    end

    assign o_time = timeReg;

endmodule

/* alarmControl.sv */
`timescale 1ns/10ps
`include "clock_consts.svh"

module alarmControl (
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic                i_editEnable,
    input  logic                i_changeAlarm,
    input  logic                i_inc,
    input  logic                i_dec,
    input  logic                i_alarmEnable,
    input  logic                i_secondTick,
    input  clockPkg::timeWord_t i_timeNow,
    input  clockPkg::timeWord_t i_alarmTime,
    output logic                o_countEnable,
    output logic                o_timeInc,
    output logic                o_timeDec,
    output logic                o_alarmInc,
    output logic                o_alarmDec,
    output clockPkg::timeWord_t o_displayWord,
    output logic                o_pm,
    output logic                o_alarmOn
);

    logic                editInc;
    logic                editDec;
    logic                counting;
    logic                alarmMatch;
    logic                alarmOn;
    clockPkg::timeWord_t displayWord;

    ////////////////////////////////////////////////////////////
    // edit routing
    ////////////////////////////////////////////////////////////

    // strobes only pass while editing
    assign editInc = i_editEnable & i_inc;
    assign editDec = i_editEnable & i_dec;

    assign o_timeInc = editInc & ~i_changeAlarm;
    assign o_timeDec = editDec & ~i_changeAlarm;
    assign o_alarmInc = editInc & i_changeAlarm;
    assign o_alarmDec = editDec & i_changeAlarm;

    // clock is frozen during edit
    assign counting = ~i_editEnable;
    assign o_countEnable = i_secondTick & counting;

    ////////////////////////////////////////////////////////////
    // display select and alarm latch
    ////////////////////////////////////////////////////////////

    assign displayWord = i_changeAlarm ? i_alarmTime : i_timeNow;
    assign o_displayWord = displayWord;
    // BCD keeps numeric order, so a plain compare works
    assign o_pm = (displayWord.fields.hours >= `PM_HOURS);

    assign alarmMatch = (i_timeNow == i_alarmTime);

    // held until the alarm is disabled
    always_ff @(posedge i_clk) begin
        if (i_rst || !i_alarmEnable) begin
            alarmOn <= 1'b0;
        end else if (counting && alarmMatch) begin
            alarmOn <= 1'b1;
        end
    end

    assign o_alarmOn = alarmOn;

endmodule

/* segmentDriver.sv */
`timescale 1ns/10ps
`include "clock_consts.svh"

module segmentDriver (
    input  logic                   i_clk,
    input  logic                   i_rst,
    input  logic                   i_scanTick,
    input  clockPkg::timeWord_t    i_word,
    output logic [6:0]             o_segments,
    output logic [`NUM_DIGITS-1:0] o_anodes
);

    localparam int IDX_W = ($clog2(`NUM_DIGITS) > 0) ? $clog2(`NUM_DIGITS) : 1;
    localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(`NUM_DIGITS - 1);

    logic [IDX_W-1:0]       digitIdx;
    logic [IDX_W-1:0]       nextIdx;
    logic [3:0]             digitValue;
    logic [6:0]             segPattern;
    logic [`NUM_DIGITS-1:0] anodePattern;
    logic [6:0]             segReg;
    logic [`NUM_DIGITS-1:0] anodeReg;

    ////////////////////////////////////////////////////////////
    // digit select
    ////////////////////////////////////////////////////////////

    assign nextIdx = (digitIdx == IDX_LAST) ? '0 : digitIdx + 1'b1;

    // digit view of the word
    assign digitValue = i_word.digits[nextIdx];

    // one-hot, active low
    assign anodePattern = ~(`NUM_DIGITS'(1) << nextIdx);

    ////////////////////////////////////////////////////////////
    // BCD to segments
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (digitValue)
            4'd0: segPattern = `SEG_0;
            4'd1: segPattern = `SEG_1;
            4'd2: segPattern = `SEG_2;
            4'd3: segPattern = `SEG_3;
            4'd4: segPattern = `SEG_4;
            4'd5: segPattern = `SEG_5;
            4'd6: segPattern = `SEG_6;
            4'd7: segPattern = `SEG_7;
            4'd8: segPattern = `SEG_8;
            4'd9: segPattern = `SEG_9;
            // not a decimal digit
            default: segPattern = `SEG_BLANK;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // scan registers
    ////////////////////////////////////////////////////////////

    // display dark after reset, first scan tick lands on digit 0
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            digitIdx <= IDX_LAST;
            anodeReg <= '1;
            segReg <= `SEG_BLANK;
        end else if (i_scanTick) begin
            digitIdx <= nextIdx;
            anodeReg <= anodePattern;
            segReg <= segPattern;
        end
    end

    assign o_segments = segReg;
    assign o_anodes = anodeReg;

endmodule

/* alarmClock.sv */
`timescale 1ns/10ps
`include "clock_consts.svh"

module alarmClock (
    input  logic                   i_clk,
    input  logic                   i_rst,
    input  logic                   i_editEnable,
    input  logic                   i_changeAlarm,
    input  clockPkg::field_t       i_field,
    input  logic                   i_inc,
    input  logic                   i_dec,
    input  logic                   i_alarmEnable,
    output logic [6:0]             o_segments,
    output logic [`NUM_DIGITS-1:0] o_anodes,
    output logic                   o_pm,
    output logic                   o_alarmOn
);

    logic                secondTick;
    logic                scanTick;
    logic                countEnable;
    logic                timeInc;
    logic                timeDec;
    logic                alarmInc;
    logic                alarmDec;
    clockPkg::timeWord_t timeNow;
    clockPkg::timeWord_t alarmTime;
    clockPkg::timeWord_t displayWord;

    ////////////////////////////////////////////////////////////
    // clock enables
    ////////////////////////////////////////////////////////////

    tickGen tickSource (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .o_secondTick (secondTick),
        .o_scanTick   (scanTick)
    );

    ////////////////////////////////////////////////////////////
    // controller
    ////////////////////////////////////////////////////////////

    alarmControl controller (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_editEnable  (i_editEnable),
        .i_changeAlarm (i_changeAlarm),
        .i_inc         (i_inc),
        .i_dec         (i_dec),
        .i_alarmEnable (i_alarmEnable),
        .i_secondTick  (secondTick),
        .i_timeNow     (timeNow),
        .i_alarmTime   (alarmTime),
        .o_countEnable (countEnable),
        .o_timeInc     (timeInc),
        .o_timeDec     (timeDec),
        .o_alarmInc    (alarmInc),
        .o_alarmDec    (alarmDec),
        .o_displayWord (displayWord),
        .o_pm          (o_pm),
        .o_alarmOn     (o_alarmOn)
    );

    ////////////////////////////////////////////////////////////
    // time and alarm registers
    ////////////////////////////////////////////////////////////

    timeKeeper #(.countMode(1'b1)) timeCounter (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_advance (countEnable),
        .i_field   (i_field),
        .i_inc     (timeInc),
        .i_dec     (timeDec),
        .o_time    (timeNow)
    );

    // alarm never counts
    timeKeeper #(.countMode(1'b0)) alarmRegister (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_advance (1'b0),
        .i_field   (i_field),
        .i_inc     (alarmInc),
        .i_dec     (alarmDec),
        .o_time    (alarmTime)
    );

    ////////////////////////////////////////////////////////////
    // display
    ////////////////////////////////////////////////////////////

    segmentDriver segDisplay (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_scanTick (scanTick),
        .i_word     (displayWord),
        .o_segments (o_segments),
        .o_anodes   (o_anodes)
    );

endmodule

/* tb_alarmClock.sv */
`timescale 1ns/10ps
`include "clock_consts.svh"

module tb_alarmClock;

    localparam int HALF_PERIOD = 4;
    localparam int SCAN_CYCLES = `NUM_DIGITS * `CLK_PER_SCAN;
    // about 60 counted seconds of 16 cycles plus roughly 5000 cycles of edits
    // and display reads with a wide margin
    localparam int TIMEOUT_CYCLES = 20000;

    logic                   i_clk;
    logic                   i_rst;
    logic                   i_editEnable;
    logic                   i_changeAlarm;
    clockPkg::field_t       i_field;
    logic                   i_inc;
    logic                   i_dec;
    logic                   i_alarmEnable;
    logic [6:0]             o_segments;
    logic [`NUM_DIGITS-1:0] o_anodes;
    logic                   o_pm;
    logic                   o_alarmOn;

    clockPkg::timeWord_t modelTime;
    clockPkg::timeWord_t modelAlarm;
    logic                monitorArmed;
    int                  cycleCount = 0;

    alarmClock dut_i (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_editEnable  (i_editEnable),
        .i_changeAlarm (i_changeAlarm),
        .i_field       (i_field),
        .i_inc         (i_inc),
        .i_dec         (i_dec),
        .i_alarmEnable (i_alarmEnable),
        .o_segments    (o_segments),
        .o_anodes      (o_anodes),
        .o_pm          (o_pm),
        .o_alarmOn     (o_alarmOn)
    );

    always #HALF_PERIOD i_clk = ~i_clk;

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    function automatic int toBin(input logic [7:0] bcd);
        return int'(bcd[7:4]) * 10 + int'(bcd[3:0]);
    endfunction

    function automatic logic [7:0] toBcd(input int value);
        return {4'(value / 10), 4'(value % 10)};
    endfunction

    function automatic int fieldValue(input clockPkg::timeWord_t w,
                                      input clockPkg::field_t field);
        case (field)
            clockPkg::FIELD_HOUR: return toBin(w.fields.hours);
            clockPkg::FIELD_MIN: return toBin(w.fields.minutes);
            default: return toBin(w.fields.seconds);
        endcase
    endfunction

    // counting done in seconds since midnight
    function automatic clockPkg::timeWord_t advanceRef(input clockPkg::timeWord_t w,
                                                       input int secs);
        clockPkg::timeWord_t result;
        int total;
        total = toBin(w.fields.hours) * 3600 + toBin(w.fields.minutes) * 60;
        total = (total + toBin(w.fields.seconds) + secs) % 86400;
        result.fields.hours = toBcd(total / 3600);
        result.fields.minutes = toBcd((total / 60) % 60);
        result.fields.seconds = toBcd(total % 60);
        return result;
    endfunction

    // one field moves modulo its range while the others stay
    function automatic clockPkg::timeWord_t editRef(input clockPkg::timeWord_t w,
                                                    input clockPkg::field_t field,
                                                    input logic inc, input logic dec);
        clockPkg::timeWord_t result;
        int value;
        int limit;
        result = w;
        limit = (field == clockPkg::FIELD_HOUR) ? 24 : 60;
        value = fieldValue(w, field);
        if (inc && !dec) begin
            value = (value + 1) % limit;
        end else if (dec && !inc) begin
            value = (value + limit - 1) % limit;
        end
        case (field)
            clockPkg::FIELD_HOUR: result.fields.hours = toBcd(value);
            clockPkg::FIELD_MIN: result.fields.minutes = toBcd(value);
            default: result.fields.seconds = toBcd(value);
        endcase
        return result;
    endfunction

    function automatic logic [6:0] segRef(input logic [3:0] digit);
        case (digit)
            4'd0: return `SEG_0;
            4'd1: return `SEG_1;
            4'd2: return `SEG_2;
            4'd3: return `SEG_3;
            4'd4: return `SEG_4;
            4'd5: return `SEG_5;
            4'd6: return `SEG_6;
            4'd7: return `SEG_7;
            4'd8: return `SEG_8;
            4'd9: return `SEG_9;
            default: return `SEG_BLANK;
        endcase
    endfunction

    function automatic logic pmRef(input clockPkg::timeWord_t w);
        return toBin(w.fields.hours) >= 12;
    endfunction

    // F marks a pattern that is no decimal digit
    function automatic logic [3:0] decodeSegments(input logic [6:0] seg);
        logic [3:0] digit;
        digit = 4'hF;
        for (int v = 0; v < 10; v++) begin
            if (segRef(4'(v)) == seg) begin
                digit = 4'(v);
            end
        end
        return digit;
    endfunction

    function automatic clockPkg::timeWord_t shownWord();
        return i_changeAlarm ? modelAlarm : modelTime;
    endfunction

    ////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////

    task automatic abortRun(input string why);
        $display("TESTBENCH FAILED");
        $fatal(1, "%s", why);
    endtask

    task automatic checkSegments(input string name, input logic [6:0] expected,
                                 input logic [6:0] actual);
        if (actual !== expected) begin
            $display("FAIL %s expected %b actual %b", name, expected, actual);
            abortRun({"segment mismatch in ", name});
        end
    endtask

    task automatic checkWord(input string name, input clockPkg::timeWord_t expected,
                             input clockPkg::timeWord_t actual);
        if (actual !== expected) begin
            $display("FAIL %s expected %h:%h:%h actual %h:%h:%h", name,
                     expected.fields.hours, expected.fields.minutes, expected.fields.seconds,
                     actual.fields.hours, actual.fields.minutes, actual.fields.seconds);
            abortRun({"displayed word mismatch in ", name});
        end
    endtask

    task automatic checkBit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAIL %s expected %b actual %b", name, expected, actual);
            abortRun({"output bit mismatch in ", name});
        end
    endtask

    ////////////////////////////////////////////////////////////
    // monitor and watchdog
    ////////////////////////////////////////////////////////////

    always @(posedge i_clk) begin : scanMonitor
        clockPkg::timeWord_t expectWord;
        if (monitorArmed && o_anodes != '1) begin
            if ($countones(~o_anodes) != 1) begin
                abortRun("anode pattern is not one-hot");
            end
            expectWord = shownWord();
            for (int i = 0; i < `NUM_DIGITS; i++) begin
                if (!o_anodes[i]) begin
                    checkSegments("scan digit", segRef(expectWord.digits[i]), o_segments);
                end
            end
        end
    end

    always @(posedge i_clk) begin : watchdog
        cycleCount++;
        if (cycleCount > TIMEOUT_CYCLES) begin
            abortRun($sformatf("timeout, run went past %0d cycles", TIMEOUT_CYCLES));
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////////////////////////

    // collects one full scan of the six digits
    task automatic readDisplay(output clockPkg::timeWord_t shown);
        logic [`NUM_DIGITS-1:0] seen;
        int waited;
        seen = '0;
        waited = 0;
        shown = '0;
        while (seen != '1) begin
            @(posedge i_clk);
            waited++;
            if (waited > 4 * SCAN_CYCLES) begin
                abortRun("display scan did not visit every digit");
            end
            for (int i = 0; i < `NUM_DIGITS; i++) begin
                if (!o_anodes[i]) begin
                    seen[i] = 1'b1;
                    shown.digits[i] = decodeSegments(o_segments);
                end
            end
        end
    endtask

    // op 0 inc, 1 dec, 2 both
    task automatic editStep(input clockPkg::field_t field, input int op);
        @(negedge i_clk);
        monitorArmed = 1'b0;
        i_field = field;
        i_inc = (op != 1);
        i_dec = (op != 0);
        if (i_changeAlarm) begin
            modelAlarm = editRef(modelAlarm, field, i_inc, i_dec);
        end else begin
            modelTime = editRef(modelTime, field, i_inc, i_dec);
        end
        @(negedge i_clk);
        i_inc = 1'b0;
        i_dec = 1'b0;
    endtask

    task automatic setField(input clockPkg::field_t field, input int target);
        while (fieldValue(shownWord(), field) != target) begin
            editStep(field, 0);
        end
    endtask

    // every digit reloaded before the monitor resumes
    task automatic checkDisplay(input string name);
        clockPkg::timeWord_t shown;
        repeat (SCAN_CYCLES + 2) @(negedge i_clk);
        monitorArmed = 1'b1;
        readDisplay(shown);
        checkWord(name, shownWord(), shown);
        checkBit({name, " pm"}, pmRef(shownWord()), o_pm);
    endtask

    task automatic randomEdits(input string name, input bit anyField,
                               input clockPkg::field_t field);
        int count;
        count = int'($urandom_range(10, 30));
        repeat (count) begin
            if (anyField) begin
                field = clockPkg::field_t'(2'($urandom_range(0, 2)));
            end
            editStep(field, int'($urandom_range(0, 2)));
            checkDisplay(name);
        end
    endtask

    task automatic selectWord(input logic alarm);
        @(negedge i_clk);
        monitorArmed = 1'b0;
        i_changeAlarm = alarm;
    endtask

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial begin : stimulus
        clockPkg::timeWord_t start;
        clockPkg::timeWord_t shown;
        int released;
        int ticks;
        int waitCycles;
        bit matched;
        void'($urandom(64036));
        i_clk = 1'b0;
        i_rst = 1'b1;
        i_editEnable = 1'b1;
        i_changeAlarm = 1'b0;
        i_field = clockPkg::FIELD_SEC;
        i_inc = 1'b0;
        i_dec = 1'b0;
        i_alarmEnable = 1'b0;
        modelTime = '0;
        modelAlarm = '0;
        monitorArmed = 1'b0;
        repeat (10) @(negedge i_clk);
        i_rst = 1'b0;

        // reset state
        checkDisplay("reset");
        checkBit("reset alarm", 1'b0, o_alarmOn);

        // field wraps then random edits per field
        editStep(clockPkg::FIELD_HOUR, 1);
        checkDisplay("hour wrap down");
        editStep(clockPkg::FIELD_HOUR, 0);
        checkDisplay("hour wrap up");
        setField(clockPkg::FIELD_SEC, 59);
        editStep(clockPkg::FIELD_SEC, 0);
        checkDisplay("second wrap");
        randomEdits("edit seconds", 1'b0, clockPkg::FIELD_SEC);
        randomEdits("edit minutes", 1'b0, clockPkg::FIELD_MIN);
        randomEdits("edit hours", 1'b0, clockPkg::FIELD_HOUR);

        // counting across midnight
        setField(clockPkg::FIELD_HOUR, 23);
        setField(clockPkg::FIELD_MIN, 59);
        setField(clockPkg::FIELD_SEC, 50);
        checkDisplay("count start");
        start = modelTime;
        released = int'($urandom_range(11 * `CLK_PER_SECOND, 19 * `CLK_PER_SECOND));
        @(negedge i_clk);
        monitorArmed = 1'b0;
        i_editEnable = 1'b0;
        repeat (released) @(negedge i_clk);
        i_editEnable = 1'b1;
        repeat (SCAN_CYCLES + 2) @(negedge i_clk);
        readDisplay(shown);
        // free-running tick phase allows one second either way
        ticks = released / `CLK_PER_SECOND;
        matched = 1'b0;
        for (int d = -1; d <= 1; d++) begin
            if (ticks + d >= 0 && advanceRef(start, ticks + d) == shown) begin
                matched = 1'b1;
                modelTime = advanceRef(start, ticks + d);
            end
        end
        if (!matched) begin
            checkWord("count advance", advanceRef(start, ticks), shown);
        end
        checkDisplay("count result");

        // alarm edits leave the time alone
        selectWord(1'b1);
        checkDisplay("alarm shown");
        randomEdits("alarm edit", 1'b1, clockPkg::FIELD_SEC);
        selectWord(1'b0);
        checkDisplay("time kept");

        // alarm three seconds ahead of a frozen time
        setField(clockPkg::FIELD_HOUR, 12);
        setField(clockPkg::FIELD_MIN, 34);
        setField(clockPkg::FIELD_SEC, 20);
        checkDisplay("alarm base");
        selectWord(1'b1);
        setField(clockPkg::FIELD_HOUR, 12);
        setField(clockPkg::FIELD_MIN, 34);
        setField(clockPkg::FIELD_SEC, 23);
        checkDisplay("alarm target");
        selectWord(1'b0);
        checkDisplay("alarm frozen");
        checkBit("alarm idle", 1'b0, o_alarmOn);
        @(negedge i_clk);
        monitorArmed = 1'b0;
        i_alarmEnable = 1'b1;
        i_editEnable = 1'b0;
        waitCycles = 0;
        do begin
            @(negedge i_clk);
            waitCycles++;
            if (waitCycles > 4 * `CLK_PER_SECOND) begin
                checkBit("alarm rise", 1'b1, o_alarmOn);
            end
        end while (!o_alarmOn);
        if (waitCycles < 2 * `CLK_PER_SECOND) begin
            abortRun("alarm rose before the time reached the alarm");
        end
        repeat (2 * `CLK_PER_SECOND) begin
            @(negedge i_clk);
            checkBit("alarm hold", 1'b1, o_alarmOn);
        end
        i_alarmEnable = 1'b0;
        @(negedge i_clk);
        checkBit("alarm clear", 1'b0, o_alarmOn);
        i_editEnable = 1'b1;

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+.
clockPkg.sv
tickGen.sv
timeKeeper.sv
alarmControl.sv
segmentDriver.sv
alarmClock.sv
tb_alarmClock.sv

/* run.sh */
#!/usr/bin/env bash
# builds the alarm clock testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --top-module tb_alarmClock \
    -f filelist.f \
    -o tb_alarmClock

./obj_dir/tb_alarmClock
